/* build.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_agu.sv
verilog/lsu_issue_buffer.sv
verilog/lsu_mem_ctrl.sv
verilog/lsu_result.sv
verilog/lsu_top.sv
verification/lsu_tb_clk_gen.sv
verification/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -f build.f -o lsu_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/lsu_tb_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

/* verification/lsu_tb.sv */
// Load/store unit testbench
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_tb;

  localparam int TIMEOUT_CYCLES = 240 * 12 + 200;

  typedef struct packed {
    logic               is_store;
    lsu_pkg::trans_id_t id;
    logic               ex;
    lsu_pkg::cause_t    cause;
    lsu_pkg::xlen_t     tval;
    lsu_pkg::xlen_t     result;
  } expect_t;

  logic clk, rst_n;
  logic lsu_valid_i, lsu_ready_o;
  lsu_pkg::lsu_op_t op_i;
  lsu_pkg::xlen_t a_i, b_i, imm_i;
  lsu_pkg::trans_id_t trans_id_i;
  logic mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  lsu_pkg::xlen_t mem_addr_o, mem_wdata_o, mem_rdata_i;
  lsu_pkg::be_t mem_be_o;
  logic load_valid_o, load_ex_valid_o, store_valid_o, store_ex_valid_o;
  lsu_pkg::trans_id_t load_trans_id_o, store_trans_id_o;
  lsu_pkg::xlen_t load_result_o, load_ex_tval_o, store_ex_tval_o;
  lsu_pkg::cause_t load_ex_cause_o, store_ex_cause_o;

  lsu_pkg::xlen_t mem_model [256];
  lsu_pkg::xlen_t shadow [256];
  expect_t expected_q [$];
  expect_t head;
  int errors = 0, tests = 0, failed_tests = 0, issued = 0, results_seen = 0;
  int cycles = 0, req_cycles = 0, gnt_delay = 0, rd_delay = 0;
  logic req_seen = 1'b0, rd_pending = 1'b0, ready_fell = 1'b0;
  logic [7:0] rd_index;
  lsu_pkg::trans_id_t next_id = '0;

  lsu_tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  lsu_top dut_i (
    .clk_i(clk), .rst_ni(rst_n), .lsu_valid_i(lsu_valid_i), .lsu_op_i(op_i),
    .operand_a_i(a_i), .operand_b_i(b_i), .imm_i(imm_i), .trans_id_i(trans_id_i),
    .lsu_ready_o(lsu_ready_o), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
    .mem_addr_o(mem_addr_o), .mem_be_o(mem_be_o), .mem_wdata_o(mem_wdata_o),
    .mem_gnt_i(mem_gnt_i), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
    .load_valid_o(load_valid_o), .load_trans_id_o(load_trans_id_o),
    .load_result_o(load_result_o), .load_ex_valid_o(load_ex_valid_o),
    .load_ex_cause_o(load_ex_cause_o), .load_ex_tval_o(load_ex_tval_o),
    .store_valid_o(store_valid_o), .store_trans_id_o(store_trans_id_o),
    .store_ex_valid_o(store_ex_valid_o), .store_ex_cause_o(store_ex_cause_o),
    .store_ex_tval_o(store_ex_tval_o)
  );

  task automatic report_mismatch(input string name, input lsu_pkg::xlen_t got,
                                 input lsu_pkg::xlen_t exp);
    errors++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Initial memory contents, distinct for every word
  function automatic lsu_pkg::xlen_t fill_word(input int index);
    lsu_pkg::xlen_t idx;
    idx = index;
    return (idx * 32'h9e37_79b1) ^ {idx[7:0], ~idx[7:0], idx[7:0], ~idx[7:0]};
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------

  // Expected completion of one request; stores update the shadow memory
  function automatic expect_t predict(input lsu_pkg::lsu_op_t op, input lsu_pkg::xlen_t a,
                                      input lsu_pkg::xlen_t b, input lsu_pkg::xlen_t imm,
                                      input lsu_pkg::trans_id_t id);
    expect_t e;
    lsu_pkg::xlen_t addr;
    lsu_pkg::xlen_t word;
    int nbytes;
    int off;
    int i;
    e = '0;
    addr = a + imm;
    off = addr[1:0];
    nbytes = 1 << op[1:0];
    e.is_store = op[3];
    e.id = id;
    if (off % nbytes != 0) begin
      e.ex = 1'b1;
      e.cause = op[3] ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;
      e.tval = addr;
    end else if (op[3]) begin
      for (i = 0; i < nbytes; i++) begin
        shadow[addr[9:2]][(off + i) * 8 +: 8] = b[i * 8 +: 8];
      end
    end else begin
      word = shadow[addr[9:2]];
      for (i = 0; i < nbytes; i++) begin
        e.result[i * 8 +: 8] = word[(off + i) * 8 +: 8];
      end
      // Signed loads copy the top loaded bit upward
      for (i = nbytes; i < 4; i++) begin
        if (!op[2] && e.result[nbytes * 8 - 1]) begin
          e.result[i * 8 +: 8] = 8'hff;
        end
      end
    end
    return e;
  endfunction

  // Caller sits on a falling edge; returns on the falling edge after acceptance
  task automatic issue(input lsu_pkg::lsu_op_t op, input lsu_pkg::xlen_t a,
                       input lsu_pkg::xlen_t b, input lsu_pkg::xlen_t imm);
    expected_q.push_back(predict(op, a, b, imm, next_id));
    lsu_valid_i = 1'b1;
    op_i = op;
    a_i = a;
    b_i = b;
    imm_i = imm;
    trans_id_i = next_id;
    while (!lsu_ready_o) begin
      ready_fell = 1'b1;
      @(negedge clk);
    end
    @(negedge clk);
    lsu_valid_i = 1'b0;
    next_id++;
    issued++;
  endtask

  task automatic drain();
    while (expected_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic compare_memory();
    int i;
    for (i = 0; i < 256; i++) begin
      if (mem_model[i] !== shadow[i]) begin
        report_mismatch($sformatf("mem_model[%0d]", i), mem_model[i], shadow[i]);
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      failed_tests++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ------------------------------
  // Memory model
  // ------------------------------

  always @(negedge clk) begin
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    if (rd_pending) begin
      if (rd_delay == 0) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i = mem_model[rd_index];
        rd_pending = 1'b0;
      end else begin
        rd_delay--;
      end
    end
    if (mem_req_o) begin
      req_cycles++;
      if (!req_seen) begin
        req_seen = 1'b1;
        gnt_delay = $urandom_range(0, 3);
      end
      if (gnt_delay == 0) begin
        mem_gnt_i = 1'b1;
        req_seen = 1'b0;
        if (mem_addr_o[1:0] != 2'b00) begin
          report_failure("mem_addr_o is not word aligned");
        end
        if (mem_we_o) begin
          for (int i = 0; i < 4; i++) begin
            if (mem_be_o[i]) begin
              mem_model[mem_addr_o[9:2]][i * 8 +: 8] = mem_wdata_o[i * 8 +: 8];
            end
          end
        end else begin
          rd_pending = 1'b1;
          rd_delay = $urandom_range(0, 2);
          rd_index = mem_addr_o[9:2];
        end
      end else begin
        gnt_delay--;
      end
    end
  end

  // ------------------------------
  // Result checker
  // ------------------------------

  always @(negedge clk) begin
    if (rst_n && (load_valid_o || store_valid_o)) begin
      if (load_valid_o && store_valid_o) begin
        report_failure("load_valid_o and store_valid_o are high together");
      end
      if (expected_q.size() == 0) begin
        report_failure("result pulse with no outstanding request");
      end else begin
        head = expected_q.pop_front();
        results_seen++;
        if (store_valid_o !== head.is_store) begin
          report_mismatch("store_valid_o", store_valid_o, head.is_store);
        end else if (head.is_store) begin
          if (store_trans_id_o !== head.id) begin
            report_mismatch("store_trans_id_o", store_trans_id_o, head.id);
          end
          if (store_ex_valid_o !== head.ex) begin
            report_mismatch("store_ex_valid_o", store_ex_valid_o, head.ex);
          end
          if (head.ex && store_ex_cause_o !== head.cause) begin
            report_mismatch("store_ex_cause_o", store_ex_cause_o, head.cause);
          end
          if (head.ex && store_ex_tval_o !== head.tval) begin
            report_mismatch("store_ex_tval_o", store_ex_tval_o, head.tval);
          end
        end else begin
          if (load_trans_id_o !== head.id) begin
            report_mismatch("load_trans_id_o", load_trans_id_o, head.id);
          end
          if (load_ex_valid_o !== head.ex) begin
            report_mismatch("load_ex_valid_o", load_ex_valid_o, head.ex);
          end
          if (head.ex && load_ex_cause_o !== head.cause) begin
            report_mismatch("load_ex_cause_o", load_ex_cause_o, head.cause);
          end
          if (head.ex && load_ex_tval_o !== head.tval) begin
            report_mismatch("load_ex_tval_o", load_ex_tval_o, head.tval);
          end
          if (load_result_o !== head.result) begin
            report_mismatch("load_result_o", load_result_o, head.result);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d results outstanding", cycles, expected_q.size());
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    int err0;
    int off;
    int n;
    int req0;
    lsu_pkg::xlen_t data;
    lsu_pkg::lsu_op_t op;
    void'($urandom(32'hf24c9b2e));
    lsu_valid_i = 1'b0;
    op_i = '0;
    a_i = '0;
    b_i = '0;
    imm_i = '0;
    trans_id_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = fill_word(i);
      shadow[i] = fill_word(i);
    end

    // Idle outputs after reset
    err0 = errors;
    @(posedge rst_n);
    repeat (3) begin
      @(negedge clk);
      if (lsu_ready_o !== 1'b1) report_mismatch("lsu_ready_o", lsu_ready_o, 1);
      if (mem_req_o !== 1'b0) report_mismatch("mem_req_o", mem_req_o, 0);
      if (load_valid_o !== 1'b0) report_mismatch("load_valid_o", load_valid_o, 0);
      if (store_valid_o !== 1'b0) report_mismatch("store_valid_o", store_valid_o, 0);
    end
    finish_test("reset state", err0);

    // Word stores then word loads through a negative offset
    err0 = errors;
    for (n = 0; n < 8; n++) begin
      issue(4'b1010, 32'h100, $urandom, n * 4);
    end
    for (n = 0; n < 8; n++) begin
      issue(4'b0010, 32'h140, '0, n * 4 - 64);
    end
    drain();
    finish_test("aligned words", err0);

    // Bit 7 and bit 15 vary with the offset to hit both extensions
    err0 = errors;
    for (off = 0; off < 4; off++) begin
      data = $urandom;
      data[7] = off[0];
      data[15] = off[1];
      issue(4'b1000, 32'h220, data, off - 16);
      issue(4'b0000, 32'h220, '0, off - 16);
      issue(4'b0100, 32'h220, '0, off - 16);
      if (off[0] == 1'b0) begin
        issue(4'b1001, 32'h230, data, off);
        issue(4'b0001, 32'h230, '0, off);
        issue(4'b0101, 32'h230, '0, off);
      end
    end
    drain();
    finish_test("bytes and halves", err0);

    // Misaligned accesses must not touch memory
    err0 = errors;
    req0 = req_cycles;
    for (off = 1; off < 4; off++) begin
      if (off[0]) begin
        issue(4'b0001, 32'h300, $urandom, off);
        issue(4'b1001, 32'h300, $urandom, off);
      end
      issue(4'b0010, 32'h304, $urandom, off);
      issue(4'b1010, 32'h304, $urandom, off);
    end
    drain();
    if (req_cycles != req0) report_failure("mem_req_o was raised for a misaligned access");
    compare_memory();
    finish_test("misaligned", err0);

    // Random mix under random memory delays
    err0 = errors;
    ready_fell = 1'b0;
    for (n = 0; n < 200; n++) begin
      op = {1'($urandom_range(0, 1)), 1'b0, 2'($urandom_range(0, 2))};
      if (!op[3] && op[1:0] != 2'd2) op[2] = 1'($urandom_range(0, 1));
      off = $urandom_range(0, 3);
      if ($urandom_range(0, 7) != 0) off = off & (3 << op[1:0]);
      issue(op, $urandom_range(0, 255) * 4, $urandom, $urandom_range(0, 63) * 4 - 128 + off);
      if ($urandom_range(0, 3) == 0) @(negedge clk);
    end
    drain();
    if (!ready_fell) report_failure("lsu_ready_o never fell while the buffer was full");
    if (results_seen != issued) report_failure("number of results differs from requests issued");
    compare_memory();
    finish_test("random mix", err0);

    $display("Tests: %0d, failing: %0d, results checked: %0d, errors: %0d",
             tests, failed_tests, results_seen, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/lsu_tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low for four rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/lsu_agu.sv */
// Address generation unit
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_agu (
  input  wire lsu_pkg::lsu_op_t op_i,
  input  wire lsu_pkg::xlen_t   operand_a_i,
  input  wire lsu_pkg::xlen_t   imm_i,
  output lsu_pkg::xlen_t        vaddr_o,
  output lsu_pkg::be_t          be_o,
  output logic                  misaligned_o
);

  logic [1:0] size;
  logic [1:0] offset;

  // Base plus signed immediate, wraps modulo 2^XLEN
  assign vaddr_o = operand_a_i + imm_i;

  assign size   = op_i[1:0];
  assign offset = vaddr_o[1:0];

  // ------------------------------
  // Byte enable
  // ------------------------------

  always_comb begin
    case (size)
      `LSU_SIZE_BYTE: begin
        be_o = lsu_pkg::be_t'(4'b0001) << offset;
      end
      `LSU_SIZE_HALF: begin
        be_o = lsu_pkg::be_t'(4'b0011) << offset;
      end
      // Word, and the unused size code treated as word
      default: begin
        be_o = '1;
      end
    endcase
  end

  // ------------------------------
  // Misaligned detection
  // ------------------------------

  always_comb begin
    case (size)
      // Byte accesses are always aligned
      `LSU_SIZE_BYTE: begin
        misaligned_o = 1'b0;
      end
      `LSU_SIZE_HALF: begin
        misaligned_o = offset[0];
      end
      default: begin
        misaligned_o = |offset;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/lsu_cfg.svh */
// Load/store unit configuration
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data path and scoreboard widths
`define LSU_XLEN 32
`define LSU_TRANS_ID_BITS 3

// Issue buffer entries
`define LSU_BUF_DEPTH 2

// Exception cause codes
`define LSU_CAUSE_BITS 5
`define LSU_CAUSE_LD_MISALIGNED 4
`define LSU_CAUSE_ST_MISALIGNED 6

// Operation code layout
`define LSU_OP_STORE_BIT 3
`define LSU_OP_UNSIGNED_BIT 2
`define LSU_SIZE_BYTE 2'd0
`define LSU_SIZE_HALF 2'd1

`endif

/* verilog/lsu_issue_buffer.sv */
// Issue request buffer
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_issue_buffer (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     push_i,
  input  wire lsu_pkg::lsu_op_t   op_i,
  input  wire lsu_pkg::xlen_t     vaddr_i,
  input  wire lsu_pkg::be_t       be_i,
  input  wire lsu_pkg::xlen_t     wdata_i,
  input  wire lsu_pkg::trans_id_t trans_id_i,
  input  wire                     misaligned_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output lsu_pkg::lsu_op_t        op_o,
  output lsu_pkg::xlen_t          vaddr_o,
  output lsu_pkg::be_t            be_o,
  output lsu_pkg::xlen_t          wdata_o,
  output lsu_pkg::trans_id_t      trans_id_o,
  output logic                    misaligned_o,
  input  wire                     pop_i
);

  localparam int PTR_BITS = $clog2(`LSU_BUF_DEPTH);
  localparam int CNT_BITS = $clog2(`LSU_BUF_DEPTH + 1);

  lsu_pkg::lsu_op_t   op_mem         [`LSU_BUF_DEPTH];
  lsu_pkg::xlen_t     vaddr_mem      [`LSU_BUF_DEPTH];
  lsu_pkg::be_t       be_mem         [`LSU_BUF_DEPTH];
  lsu_pkg::xlen_t     wdata_mem      [`LSU_BUF_DEPTH];
  lsu_pkg::trans_id_t trans_id_mem   [`LSU_BUF_DEPTH];
  logic               misaligned_mem [`LSU_BUF_DEPTH];

  logic [PTR_BITS-1:0] wptr_q;
  logic [PTR_BITS-1:0] rptr_q;
  logic [CNT_BITS-1:0] count_q;

  assign ready_o = (count_q != CNT_BITS'(`LSU_BUF_DEPTH));
  assign valid_o = (count_q != '0);

  // Head of the queue
  assign op_o         = op_mem[rptr_q];
  assign vaddr_o      = vaddr_mem[rptr_q];
  assign be_o         = be_mem[rptr_q];
  assign wdata_o      = wdata_mem[rptr_q];
  assign trans_id_o   = trans_id_mem[rptr_q];
  assign misaligned_o = misaligned_mem[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      op_mem[wptr_q]         <= op_i;
      vaddr_mem[wptr_q]      <= vaddr_i;
      be_mem[wptr_q]         <= be_i;
      wdata_mem[wptr_q]      <= wdata_i;
      trans_id_mem[wptr_q]   <= trans_id_i;
      misaligned_mem[wptr_q] <= misaligned_i;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= (wptr_q == PTR_BITS'(`LSU_BUF_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q <= (rptr_q == PTR_BITS'(`LSU_BUF_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> ready_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_o);

endmodule

`default_nettype wire

/* verilog/lsu_mem_ctrl.sv */
// Data memory controller
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_mem_ctrl (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     valid_i,
  input  wire lsu_pkg::lsu_op_t   op_i,
  input  wire lsu_pkg::xlen_t     vaddr_i,
  input  wire lsu_pkg::be_t       be_i,
  input  wire lsu_pkg::xlen_t     wdata_i,
  input  wire lsu_pkg::trans_id_t trans_id_i,
  input  wire                     misaligned_i,
  output logic                    pop_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output lsu_pkg::xlen_t          mem_addr_o,
  output lsu_pkg::be_t            mem_be_o,
  output lsu_pkg::xlen_t          mem_wdata_o,
  input  wire                     mem_gnt_i,
  input  wire                     mem_rvalid_i,
  input  wire lsu_pkg::xlen_t     mem_rdata_i,
  output logic                    done_o,
  output lsu_pkg::lsu_op_t        done_op_o,
  output lsu_pkg::trans_id_t      done_trans_id_o,
  output lsu_pkg::xlen_t          done_vaddr_o,
  output lsu_pkg::xlen_t          done_rdata_o,
  output logic                    done_misaligned_o
);

  lsu_pkg::mem_state_e state_q, state_d;
  logic                done_d;

  // Request being served
  lsu_pkg::lsu_op_t   op_q;
  lsu_pkg::xlen_t     vaddr_q;
  lsu_pkg::be_t       be_q;
  lsu_pkg::xlen_t     wdata_q;
  lsu_pkg::trans_id_t trans_id_q;
  logic               misaligned_q;
  lsu_pkg::xlen_t     rdata_q;

  // ------------------------------
  // Memory port
  // ------------------------------

  assign mem_req_o   = (state_q == lsu_pkg::WAIT_GNT);
  assign mem_we_o    = op_q[`LSU_OP_STORE_BIT];
  assign mem_addr_o  = {vaddr_q[`LSU_XLEN-1:2], 2'b00};
  assign mem_be_o    = be_q;
  // Store data moved up to its byte lane
  assign mem_wdata_o = wdata_q << {vaddr_q[1:0], 3'b000};

  // ------------------------------
  // FSM
  // ------------------------------

  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    done_d  = 1'b0;
    unique case (state_q)
      lsu_pkg::IDLE: begin
        if (valid_i) begin
          pop_o = 1'b1;
          // Misaligned requests skip memory entirely
          if (misaligned_i) begin
            done_d = 1'b1;
          end else begin
            state_d = lsu_pkg::WAIT_GNT;
          end
        end
      end
      lsu_pkg::WAIT_GNT: begin
        if (mem_gnt_i) begin
          if (op_q[`LSU_OP_STORE_BIT]) begin
            done_d  = 1'b1;
            state_d = lsu_pkg::IDLE;
          end else begin
            state_d = lsu_pkg::WAIT_RVALID;
          end
        end
      end
      lsu_pkg::WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          done_d  = 1'b1;
          state_d = lsu_pkg::IDLE;
        end
      end
      default: state_d = lsu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lsu_pkg::IDLE;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_o  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      op_q         <= op_i;
      vaddr_q      <= vaddr_i;
      be_q         <= be_i;
      wdata_q      <= wdata_i;
      trans_id_q   <= trans_id_i;
      misaligned_q <= misaligned_i;
    end
    if (state_q == lsu_pkg::WAIT_RVALID && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign done_op_o         = op_q;
  assign done_trans_id_o   = trans_id_q;
  assign done_vaddr_o      = vaddr_q;
  assign done_rdata_o      = rdata_q;
  assign done_misaligned_o = misaligned_q;

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_be_o) && $stable(mem_wdata_o));
  a_rvalid_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> state_q == lsu_pkg::WAIT_RVALID);

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
// Load/store unit types
`default_nettype none
`include "lsu_cfg.svh"

package lsu_pkg;

  // ------------------------------
  // Data path vectors
  // ------------------------------

  // Operand, result and address
  typedef logic [`LSU_XLEN-1:0] xlen_t;

  // One enable per byte lane
  typedef logic [`LSU_XLEN/8-1:0] be_t;

  typedef logic [`LSU_TRANS_ID_BITS-1:0] trans_id_t;

  typedef logic [`LSU_CAUSE_BITS-1:0] cause_t;

  // Bit 3 store, bit 2 unsigned, bits 1:0 transfer size
  typedef logic [3:0] lsu_op_t;

  // ------------------------------
  // Memory controller
  // ------------------------------

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } mem_state_e;

endpackage

`default_nettype wire

/* verilog/lsu_result.sv */
// Load and store result stage
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_result (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     done_i,
  input  wire lsu_pkg::lsu_op_t   done_op_i,
  input  wire lsu_pkg::trans_id_t done_trans_id_i,
  input  wire lsu_pkg::xlen_t     done_vaddr_i,
  input  wire lsu_pkg::xlen_t     done_rdata_i,
  input  wire                     done_misaligned_i,
  output logic                    load_valid_o,
  output lsu_pkg::trans_id_t      load_trans_id_o,
  output lsu_pkg::xlen_t          load_result_o,
  output logic                    load_ex_valid_o,
  output lsu_pkg::cause_t         load_ex_cause_o,
  output lsu_pkg::xlen_t          load_ex_tval_o,
  output logic                    store_valid_o,
  output lsu_pkg::trans_id_t      store_trans_id_o,
  output logic                    store_ex_valid_o,
  output lsu_pkg::cause_t         store_ex_cause_o,
  output lsu_pkg::xlen_t          store_ex_tval_o
);

  logic           is_store;
  logic           sign_ext;
  lsu_pkg::xlen_t shifted;
  lsu_pkg::xlen_t extended;

  assign is_store = done_op_i[`LSU_OP_STORE_BIT];
  assign sign_ext = !done_op_i[`LSU_OP_UNSIGNED_BIT];

  // Bring the addressed lane down to bit 0
  assign shifted = done_rdata_i >> {done_vaddr_i[1:0], 3'b000};

  always_comb begin
    case (done_op_i[1:0])
      `LSU_SIZE_BYTE: extended = {{(`LSU_XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
      `LSU_SIZE_HALF: extended = {{(`LSU_XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
      default:        extended = shifted;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_valid_o     <= 1'b0;
      store_valid_o    <= 1'b0;
      load_ex_valid_o  <= 1'b0;
      store_ex_valid_o <= 1'b0;
    end else begin
      load_valid_o     <= done_i && !is_store;
      store_valid_o    <= done_i && is_store;
      load_ex_valid_o  <= done_i && !is_store && done_misaligned_i;
      store_ex_valid_o <= done_i && is_store && done_misaligned_i;
    end
  end

  // Faulting accesses report the address and return zero
  always_ff @(posedge clk_i) begin
    if (done_i) begin
      load_trans_id_o  <= done_trans_id_i;
      store_trans_id_o <= done_trans_id_i;
      load_result_o    <= done_misaligned_i ? '0 : extended;
      load_ex_cause_o  <= done_misaligned_i ?
                          lsu_pkg::cause_t'(`LSU_CAUSE_LD_MISALIGNED) : '0;
      store_ex_cause_o <= done_misaligned_i ?
                          lsu_pkg::cause_t'(`LSU_CAUSE_ST_MISALIGNED) : '0;
      load_ex_tval_o   <= done_misaligned_i ? done_vaddr_i : '0;
      store_ex_tval_o  <= done_misaligned_i ? done_vaddr_i : '0;
    end
  end

  // Only aligned accesses reach the lane shift
  a_aligned_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i && !done_misaligned_i && done_op_i[1:0] != `LSU_SIZE_BYTE
      |-> !done_vaddr_i[0] && (done_op_i[1:0] == `LSU_SIZE_HALF || !done_vaddr_i[1]));

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// Load/store unit top level
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  // Issue side
  input  wire                     lsu_valid_i,
  input  wire lsu_pkg::lsu_op_t   lsu_op_i,
  input  wire lsu_pkg::xlen_t     operand_a_i,
  input  wire lsu_pkg::xlen_t     operand_b_i,
  input  wire lsu_pkg::xlen_t     imm_i,
  input  wire lsu_pkg::trans_id_t trans_id_i,
  output logic                    lsu_ready_o,
  // Data memory port
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output lsu_pkg::xlen_t          mem_addr_o,
  output lsu_pkg::be_t            mem_be_o,
  output lsu_pkg::xlen_t          mem_wdata_o,
  input  wire                     mem_gnt_i,
  input  wire                     mem_rvalid_i,
  input  wire lsu_pkg::xlen_t     mem_rdata_i,
  // Results
  output logic                    load_valid_o,
  output lsu_pkg::trans_id_t      load_trans_id_o,
  output lsu_pkg::xlen_t          load_result_o,
  output logic                    load_ex_valid_o,
  output lsu_pkg::cause_t         load_ex_cause_o,
  output lsu_pkg::xlen_t          load_ex_tval_o,
  output logic                    store_valid_o,
  output lsu_pkg::trans_id_t      store_trans_id_o,
  output logic                    store_ex_valid_o,
  output lsu_pkg::cause_t         store_ex_cause_o,
  output lsu_pkg::xlen_t          store_ex_tval_o
);

  lsu_pkg::xlen_t     agu_vaddr, head_vaddr, head_wdata, done_vaddr, done_rdata;
  lsu_pkg::be_t       agu_be, head_be;
  lsu_pkg::lsu_op_t   head_op, done_op;
  lsu_pkg::trans_id_t head_trans_id, done_trans_id;
  logic               agu_misaligned, head_valid, head_misaligned, pop, done, done_misaligned;

  lsu_agu i_agu (
    .op_i(lsu_op_i), .operand_a_i(operand_a_i), .imm_i(imm_i),
    .vaddr_o(agu_vaddr), .be_o(agu_be), .misaligned_o(agu_misaligned)
  );

  // Push on the issue handshake
  lsu_issue_buffer i_buffer (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(lsu_valid_i && lsu_ready_o),
    .op_i(lsu_op_i), .vaddr_i(agu_vaddr), .be_i(agu_be), .wdata_i(operand_b_i),
    .trans_id_i(trans_id_i), .misaligned_i(agu_misaligned), .ready_o(lsu_ready_o),
    .valid_o(head_valid), .op_o(head_op), .vaddr_o(head_vaddr), .be_o(head_be),
    .wdata_o(head_wdata), .trans_id_o(head_trans_id), .misaligned_o(head_misaligned),
    .pop_i(pop)
  );

  lsu_mem_ctrl i_mem_ctrl (
    .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(head_valid), .op_i(head_op),
    .vaddr_i(head_vaddr), .be_i(head_be), .wdata_i(head_wdata),
    .trans_id_i(head_trans_id), .misaligned_i(head_misaligned), .pop_o(pop),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_be_o(mem_be_o), .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i), .done_o(done),
    .done_op_o(done_op), .done_trans_id_o(done_trans_id), .done_vaddr_o(done_vaddr),
    .done_rdata_o(done_rdata), .done_misaligned_o(done_misaligned)
  );

  lsu_result i_result (
    .clk_i(clk_i), .rst_ni(rst_ni), .done_i(done), .done_op_i(done_op),
    .done_trans_id_i(done_trans_id), .done_vaddr_i(done_vaddr),
    .done_rdata_i(done_rdata), .done_misaligned_i(done_misaligned),
    .load_valid_o(load_valid_o), .load_trans_id_o(load_trans_id_o),
    .load_result_o(load_result_o), .load_ex_valid_o(load_ex_valid_o),
    .load_ex_cause_o(load_ex_cause_o), .load_ex_tval_o(load_ex_tval_o),
    .store_valid_o(store_valid_o), .store_trans_id_o(store_trans_id_o),
    .store_ex_valid_o(store_ex_valid_o), .store_ex_cause_o(store_ex_cause_o),
    .store_ex_tval_o(store_ex_tval_o)
  );

endmodule

`default_nettype wire
